// ==== kcpu_isa_pkg.sv ====
// ISA encodings for the small core. Undefined opcodes run as NOP and stores leave CC untouched
package kcpu_isa_pkg;

    // Opcode group, bits 7:6
    localparam logic [1:0] GRP_ALU  = 2'b00;
    localparam logic [1:0] GRP_ST   = 2'b01;
    localparam logic [1:0] GRP_BR   = 2'b10;
    localparam logic [1:0] GRP_MISC = 2'b11;

    // ALU function, bits 5:3 of ALU and store opcodes
    typedef enum logic [2:0] {
        FN_LD,
        FN_ADD,
        FN_ADC,
        FN_SUB,
        FN_AND,
        FN_OR,
        FN_EOR,
        FN_CMP
    } alu_fn_e;

    // Addressing mode, bits 1:0
    localparam logic [1:0] MODE_IMM = 2'd0;
    localparam logic [1:0] MODE_EXT = 2'd1;   // 16-bit address, high byte first
    localparam logic [1:0] MODE_IDX = 2'd2;   // ,X+

    // Branch condition, bits 5:4 of branch opcodes
    localparam logic [1:0] COND_ALWAYS = 2'd0;
    localparam logic [1:0] COND_EQ     = 2'd1;
    localparam logic [1:0] COND_NE     = 2'd2;
    localparam logic [1:0] COND_CS     = 2'd3;

    // CC bit positions, upper nibble stays zero
    localparam int CC_C = 0;
    localparam int CC_V = 1;
    localparam int CC_Z = 2;
    localparam int CC_N = 3;

    // Misc group opcodes
    localparam logic [7:0] OP_LDX = 8'hC0;   // Followed by X high, X low
    localparam logic [7:0] OP_NOP = 8'hC1;

    // One opcode byte, two readings
    typedef union packed {
        struct packed {
            logic [1:0] grp;
            alu_fn_e    fn;
            logic       rsel;     // 0 selects A, 1 selects B
            logic [1:0] mode;
        } alu;
        struct packed {
            logic [1:0] grp;
            logic [1:0] cond;
            logic [3:0] unused;
        } br;
    } op_u;

endpackage

// ==== kcpu_bus_pkg.sv ====
// Sequencer strobes and bus word. The address bus is 16 bits wide with no paging
package kcpu_bus_pkg;

    localparam int MEM_AW = 16;

    // Sequencer states as one-hot bit positions
    localparam int NSTATE  = 8;
    localparam int S_FETCH = 0;
    localparam int S_OPND  = 1;
    localparam int S_ADRH  = 2;
    localparam int S_ADRL  = 3;
    localparam int S_DATA  = 4;
    localparam int S_STORE = 5;
    localparam int S_XHI   = 6;
    localparam int S_XLO   = 7;

    typedef enum logic [1:0] {
        ASEL_PC,
        ASEL_EA,
        ASEL_X
    } addr_sel_e;

    typedef struct packed {
        addr_sel_e             addr_sel;
        logic                  rd;
        logic                  wr;
        logic                  fetch;      // Opcode read
        logic                  pc_inc;
        logic                  ea_hi_ld;
        logic                  ea_lo_ld;
        logic                  op_ld;      // mdata holds the opcode
        logic                  up_acc;
        logic                  up_cc;
        logic                  up_xhi;
        logic                  up_xlo;
        logic                  x_inc;
        logic                  br_take;
        logic                  st_sel;
        kcpu_isa_pkg::alu_fn_e alu_fn;
    } ctrl_s;

    typedef struct packed {
        logic [MEM_AW-1:0] addr;
        logic [7:0]        dout;
        logic              we;
        logic              is_op;
    } bus_s;

endpackage

// ==== kcpu_alu.sv ====
// Combinational 8-bit ALU. Logic ops and loads keep C, and cmp only sets flags
`timescale 1ns/1ps

module kcpu_alu import kcpu_isa_pkg::*; (
    input  alu_fn_e    fn,
    input  logic [7:0] opnd0,    // Accumulator
    input  logic [7:0] opnd1,    // Memory byte
    input  logic [7:0] cc_in,
    output logic [7:0] rslt,
    output logic [7:0] cc_out
);

    logic [8:0] add9;
    logic [8:0] sub9;
    logic       v;
    logic       c;

    assign add9 = {1'b0, opnd0} + {1'b0, opnd1} + 9'(fn == FN_ADC && cc_in[CC_C]);
    assign sub9 = {1'b0, opnd0} - {1'b0, opnd1};   // Bit 8 is the borrow

    always_comb begin
        v = 1'b0;
        c = cc_in[CC_C];
        case (fn)
            FN_LD:  rslt = opnd1;
            FN_ADD,
            FN_ADC: begin
                rslt = add9[7:0];
                c    = add9[8];
                v    = (opnd0[7] == opnd1[7]) && (add9[7] != opnd0[7]);
            end
            FN_SUB,
            FN_CMP: begin
                rslt = sub9[7:0];
                c    = sub9[8];
                v    = (opnd0[7] != opnd1[7]) && (sub9[7] != opnd0[7]);
            end
            FN_AND: rslt = opnd0 & opnd1;
            FN_OR:  rslt = opnd0 | opnd1;
            FN_EOR: rslt = opnd0 ^ opnd1;
            default: rslt = opnd1;
        endcase

        cc_out       = cc_in;
        cc_out[CC_N] = rslt[7];
        cc_out[CC_Z] = rslt == 8'd0;
        cc_out[CC_V] = v;
        cc_out[CC_C] = c;
    end

endmodule

// ==== kcpu_regs.sv ====
// Register file. op, ea and pc bypass mdata in the cycle when that byte is first usable
`timescale 1ns/1ps

module kcpu_regs import kcpu_isa_pkg::*, kcpu_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cen,
    input  ctrl_s       ctrl,
    input  logic [7:0]  mdata,
    input  logic [7:0]  rslt,
    input  logic [7:0]  cc_out,
    output op_u         op,
    output logic [15:0] pc,
    output logic [15:0] x,
    output logic [15:0] ea,
    output logic [7:0]  a_opnd,
    output logic [7:0]  cc,
    output logic [7:0]  st_data
);

    logic [7:0]  a;
    logic [7:0]  b;
    logic [15:0] pc_q;
    logic [15:0] br_ofs;
    logic [7:0]  ea_hi;
    logic [7:0]  ea_lo;
    op_u         op_q;

    assign op      = ctrl.op_ld ? op_u'(mdata) : op_q;
    assign br_ofs  = {{8{mdata[7]}}, mdata};
    assign pc      = ctrl.br_take ? pc_q + br_ofs : pc_q;   // pc_q already past the offset
    assign ea      = {ea_hi, ctrl.ea_lo_ld ? mdata : ea_lo};
    assign a_opnd  = op.alu.rsel ? b : a;
    assign st_data = ctrl.st_sel ? b : a;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a    <= 8'd0;
            b    <= 8'd0;
            x    <= 16'd0;
            pc_q <= 16'd0;
            cc   <= 8'd0;
            op_q <= op_u'(OP_NOP);
        end else if (cen) begin
            if (ctrl.pc_inc || ctrl.br_take) begin
                pc_q <= pc + 16'(ctrl.pc_inc);
            end
            if (ctrl.op_ld) op_q <= op;
            if (ctrl.up_acc) begin
                if (op.alu.rsel) begin
                    b <= rslt;
                end else begin
                    a <= rslt;
                end
            end
            if (ctrl.up_cc) cc <= cc_out;
            if (ctrl.x_inc) x <= x + 16'd1;
            if (ctrl.up_xhi) x[15:8] <= mdata;
            if (ctrl.up_xlo) x[7:0] <= mdata;
        end
    end

    // Extended address bytes
    always_ff @(posedge clk) begin
        if (cen) begin
            if (ctrl.ea_hi_ld) ea_hi <= mdata;
            if (ctrl.ea_lo_ld) ea_lo <= mdata;
        end
    end

endmodule

// ==== kcpu_ctrl.sv ====
// Sequencer. halt only acts at an opcode fetch, and a read byte is used one cen after it arrives
`timescale 1ns/1ps

module kcpu_ctrl import kcpu_isa_pkg::*, kcpu_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,
    input  logic       halt,
    input  op_u        op,
    input  logic [7:0] cc,
    output ctrl_s      ctrl
);

    logic [NSTATE-1:0] last;      // State of the previous bus cycle
    logic [NSTATE-1:0] cur;       // State of this bus cycle
    logic [NSTATE-1:0] dec_st;
    logic              fetched;   // Previous fetch really read an opcode
    logic              is_alu;
    logic              is_st;
    logic              is_br;
    logic              cond_ok;
    logic              wb_alu;

    assign is_alu = op.alu.grp == GRP_ALU;
    assign is_st  = op.alu.grp == GRP_ST;
    assign is_br  = op.br.grp == GRP_BR;

    always_comb begin
        case (op.br.cond)
            COND_ALWAYS: cond_ok = 1'b1;
            COND_EQ:     cond_ok = cc[CC_Z];
            COND_NE:     cond_ok = !cc[CC_Z];
            COND_CS:     cond_ok = cc[CC_C];
            default:     cond_ok = 1'b1;
        endcase
    end

    // First state after the opcode byte has arrived
    always_comb begin
        dec_st = '0;
        case (op.alu.grp)
            GRP_ALU: begin
                case (op.alu.mode)
                    MODE_IMM: dec_st[S_OPND]  = 1'b1;
                    MODE_EXT: dec_st[S_ADRH]  = 1'b1;
                    MODE_IDX: dec_st[S_DATA]  = 1'b1;
                    default:  dec_st[S_FETCH] = 1'b1;
                endcase
            end
            GRP_ST: begin
                case (op.alu.mode)
                    MODE_EXT: dec_st[S_ADRH]  = 1'b1;
                    MODE_IDX: dec_st[S_STORE] = 1'b1;
                    default:  dec_st[S_FETCH] = 1'b1;   // No immediate store
                endcase
            end
            GRP_BR:   dec_st[S_OPND] = 1'b1;
            GRP_MISC: dec_st[(op == OP_LDX) ? S_XHI : S_FETCH] = 1'b1;
            default:  dec_st[S_FETCH] = 1'b1;
        endcase
    end

    always_comb begin
        cur = '0;
        case (1'b1)
            last[S_FETCH]: begin
                if (fetched) begin
                    cur = dec_st;
                end else begin
                    cur[S_FETCH] = 1'b1;   // Halted fetch is retried
                end
            end
            last[S_ADRH]: cur[S_ADRL] = 1'b1;
            last[S_ADRL]: cur[is_st ? S_STORE : S_DATA] = 1'b1;
            last[S_XHI]:  cur[S_XLO] = 1'b1;
            default:      cur[S_FETCH] = 1'b1;
        endcase
    end

    always_comb begin
        ctrl          = '0;
        ctrl.addr_sel = ASEL_PC;
        ctrl.alu_fn   = op.alu.fn;
        ctrl.st_sel   = op.alu.rsel;
        if (cur[S_FETCH]) begin
            ctrl.rd     = !halt;
            ctrl.fetch  = !halt;
            ctrl.pc_inc = !halt;
        end
        if (cur[S_OPND] | cur[S_ADRH] | cur[S_ADRL] | cur[S_XHI] | cur[S_XLO]) begin
            ctrl.rd     = 1'b1;
            ctrl.pc_inc = 1'b1;
        end
        if (cur[S_DATA] | cur[S_STORE]) begin
            ctrl.addr_sel = (op.alu.mode == MODE_IDX) ? ASEL_X : ASEL_EA;
            ctrl.x_inc    = op.alu.mode == MODE_IDX;   // Post-increment
            ctrl.rd       = cur[S_DATA];
            ctrl.wr       = cur[S_STORE];
        end
        // What to do with the byte read last cycle
        wb_alu        = last[S_DATA] | (last[S_OPND] & is_alu);
        ctrl.op_ld    = last[S_FETCH] & fetched;
        ctrl.ea_hi_ld = last[S_ADRH];
        ctrl.ea_lo_ld = last[S_ADRL];
        ctrl.up_xhi   = last[S_XHI];
        ctrl.up_xlo   = last[S_XLO];
        ctrl.up_cc    = wb_alu;
        ctrl.up_acc   = wb_alu & (op.alu.fn != FN_CMP);
        ctrl.br_take  = last[S_OPND] & is_br & cond_ok;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last    <= NSTATE'(1) << S_FETCH;
            fetched <= 1'b0;
        end else if (cen) begin
            last    <= cur;
            fetched <= ctrl.fetch;
        end
    end

    // Decode must always land on exactly one state
    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(last) && $onehot(cur));

endmodule

// ==== kcpu_memctrl.sv ====
// Bus side. cen runs at half the cen2 rate and the bus pins lag the sequencer by one clock
`timescale 1ns/1ps

module kcpu_memctrl import kcpu_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cen2,
    input  logic        dtack,
    input  ctrl_s       ctrl,
    input  logic [15:0] pc,
    input  logic [15:0] ea,
    input  logic [15:0] x,
    input  logic [7:0]  st_data,
    input  logic [7:0]  din,
    output logic        cen,
    output bus_s        bus,
    output logic [7:0]  mdata
);

    logic              phase;
    logic [MEM_AW-1:0] addr_mux;

    assign cen = cen2 & dtack & phase;   // Low dtack freezes everything

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= 1'b0;
        end else if (cen2 && dtack) begin
            phase <= ~phase;
        end
    end

    always_comb begin
        case (ctrl.addr_sel)
            ASEL_EA: addr_mux = ea;
            ASEL_X:  addr_mux = x;
            default: addr_mux = pc;
        endcase
    end

    // Registered pins settle a clock after each cen, well before the next one
    always_ff @(posedge clk) begin
        bus.addr <= addr_mux;
        if (ctrl.wr) bus.dout <= st_data;
        if (!rst_n) begin
            bus.we    <= 1'b0;
            bus.is_op <= 1'b0;
        end else begin
            bus.we    <= ctrl.wr;
            bus.is_op <= ctrl.fetch;
        end
    end

    always_ff @(posedge clk) begin
        if (cen && ctrl.rd) mdata <= din;
    end

    // A cycle that ends with we high must not also capture read data
    a_no_rd_on_write: assert property (@(posedge clk) disable iff (!rst_n)
        cen && bus.we |-> !ctrl.rd);

endmodule

// ==== kcpu.sv ====
// Core top with a 16-bit address bus and no interrupts. Each bus cycle takes two cen2 pulses
`timescale 1ns/1ps

module kcpu import kcpu_isa_pkg::*, kcpu_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen2,
    input  logic              dtack,
    input  logic              halt,
    input  logic [7:0]        din,
    output logic              cen_out,
    output logic [7:0]        dout,
    output logic [MEM_AW-1:0] addr,
    output logic              we,
    output logic              is_op
);

    ctrl_s       ctrl;
    bus_s        bus;
    op_u         op;
    logic        cen;
    logic [15:0] pc;
    logic [15:0] x;
    logic [15:0] ea;
    logic [7:0]  mdata;
    logic [7:0]  a_opnd;
    logic [7:0]  cc;
    logic [7:0]  st_data;
    logic [7:0]  rslt;
    logic [7:0]  cc_out;

    assign cen_out = cen;
    assign addr    = bus.addr;
    assign dout    = bus.dout;
    assign we      = bus.we;
    assign is_op   = bus.is_op;

    kcpu_ctrl u_ctrl (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .cen     ( cen     ),
        .halt    ( halt    ),
        .op      ( op      ),
        .cc      ( cc      ),
        .ctrl    ( ctrl    )
    );

    kcpu_memctrl u_memctrl (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .cen2    ( cen2    ),
        .dtack   ( dtack   ),
        .ctrl    ( ctrl    ),
        .pc      ( pc      ),
        .ea      ( ea      ),
        .x       ( x       ),
        .st_data ( st_data ),
        .din     ( din     ),
        .cen     ( cen     ),
        .bus     ( bus     ),
        .mdata   ( mdata   )
    );

    kcpu_regs u_regs (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .cen     ( cen     ),
        .ctrl    ( ctrl    ),
        .mdata   ( mdata   ),
        .rslt    ( rslt    ),
        .cc_out  ( cc_out  ),
        .op      ( op      ),
        .pc      ( pc      ),
        .x       ( x       ),
        .ea      ( ea      ),
        .a_opnd  ( a_opnd  ),
        .cc      ( cc      ),
        .st_data ( st_data )
    );

    kcpu_alu u_alu (
        .fn      ( ctrl.alu_fn ),
        .opnd0   ( a_opnd      ),
        .opnd1   ( mdata       ),
        .cc_in   ( cc          ),
        .rslt    ( rslt        ),
        .cc_out  ( cc_out      )
    );

    // Fetch and store never share a bus cycle
    a_op_not_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(we && is_op));

endmodule

// ==== kcpu_checker.sv ====
// Write and halt checker for kcpu. Holds at most 256 expected writes and needs a reset between tests
`timescale 1ns/1ps

module kcpu_checker (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         cen_out,
    input  logic         we,
    input  logic         is_op,
    input  logic         halt,
    input  logic [15:0]  addr,
    input  logic [7:0]   dout,
    input  logic [23:0]  exp_list [256],   // {addr, data} in bus order
    input  int           exp_n,
    input  logic [127:0] test_name,
    input  logic         test_end,
    output int           wr_cnt,
    output int           err_val,
    output int           err_extra,
    output int           err_missing,
    output int           err_halt
);

    int   n_val = 0;
    int   n_extra = 0;
    int   n_missing = 0;
    int   n_halt = 0;
    int   wr_idx = 0;
    int   halt_len = 0;
    logic halt_q = 1'b0;

    assign wr_cnt      = wr_idx;
    assign err_val     = n_val;
    assign err_extra   = n_extra;
    assign err_missing = n_missing;
    assign err_halt    = n_halt;

    always @(posedge clk) begin
        if (!rst_n) begin
            wr_idx = 0;
        end else if (cen_out && we) begin
            // A store fetched just before halt may still finish
            if (halt && halt_len > 20) begin
                n_halt++;
                $display("%0s: write to %04h while halt has been high for %0d clocks",
                         test_name, addr, halt_len);
            end
            if (wr_idx >= exp_n) begin
                n_extra++;
                $display("%0s: extra write %04h=%02h after all %0d expected writes",
                         test_name, addr, dout, exp_n);
            end else if (exp_list[wr_idx] != {addr, dout}) begin
                n_val++;
                $display("[ERROR] %0s: write %0d expected %04h=%02h, actual %04h=%02h",
                         test_name, wr_idx, exp_list[wr_idx][23:8], exp_list[wr_idx][7:0],
                         addr, dout);
            end
            wr_idx++;
        end

        // Halt must already have been high in the previous clock
        if (rst_n && cen_out && is_op && halt && halt_q) begin
            n_halt++;
            $display("%0s: opcode fetch at %04h while halt is high", test_name, addr);
        end

        if (test_end && wr_idx < exp_n) begin
            n_missing += exp_n - wr_idx;
            $display("%0s: %0d expected writes never happened", test_name, exp_n - wr_idx);
        end

        halt_len = halt ? halt_len + 1 : 0;
        halt_q   = halt;
    end

endmodule

// ==== kcpu_tb.sv ====
// Testbench for kcpu. Programs start at 0000h, data sits at 4000h and above, no program reads its own writes
`timescale 1ns/1ps

module kcpu_tb import kcpu_isa_pkg::*, kcpu_bus_pkg::*; ();

    localparam int STALL    = 8;    // Worst case slow-down with random cen2 and dtack
    localparam int HALT_LEN = 60;

    logic              clk = 1'b0;
    logic              rst_n = 1'b0;
    logic              cen2 = 1'b1;
    logic              dtack = 1'b1;
    logic              halt = 1'b0;
    logic [7:0]        din;
    logic              cen_out;
    logic [7:0]        dout;
    logic [MEM_AW-1:0] addr;
    logic              we;
    logic              is_op;

    logic [7:0]   img [65536];       // Program image
    logic [7:0]   mem [65536];       // Memory seen by the DUT
    logic [7:0]   rm [65536];        // Reference model copy
    logic         load_img = 1'b0;
    logic [23:0]  exp_list [256];
    int           exp_n = 0;
    logic [127:0] test_name = '0;
    logic         test_end = 1'b0;
    logic         stall_en = 1'b0;
    logic [31:0]  rng = 32'h2c43dff4;
    logic [31:0]  seed_alu;
    logic [15:0]  pb;                // Builder pointer
    int           cyc = 0;           // Clocks since reset release
    int           limit = 0;
    int           wr_cnt;
    int           err_val;
    int           err_extra;
    int           err_missing;
    int           err_halt;

    always #4 clk = ~clk;

    kcpu dut (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .cen2    ( cen2    ),
        .dtack   ( dtack   ),
        .halt    ( halt    ),
        .din     ( din     ),
        .cen_out ( cen_out ),
        .dout    ( dout    ),
        .addr    ( addr    ),
        .we      ( we      ),
        .is_op   ( is_op   )
    );

    kcpu_checker chk (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .cen_out     ( cen_out     ),
        .we          ( we          ),
        .is_op       ( is_op       ),
        .halt        ( halt        ),
        .addr        ( addr        ),
        .dout        ( dout        ),
        .exp_list    ( exp_list    ),
        .exp_n       ( exp_n       ),
        .test_name   ( test_name   ),
        .test_end    ( test_end    ),
        .wr_cnt      ( wr_cnt      ),
        .err_val     ( err_val     ),
        .err_extra   ( err_extra   ),
        .err_missing ( err_missing ),
        .err_halt    ( err_halt    )
    );

    assign din = mem[addr];   // Combinational read

    always @(posedge clk) begin
        if (load_img) begin
            for (int i = 0; i < 65536; i++) mem[i] <= img[i];
        end else if (cen_out && we) begin
            mem[addr] <= dout;
        end
    end

    // Bus enables, randomly dropped only in the back-pressure run
    always @(posedge clk) begin
        #1;
        if (stall_en) begin
            rng   = lcg_step(rng);
            cen2  = rng[28];
            dtack = rng[31:30] != 2'b00;
        end else begin
            cen2  = 1'b1;
            dtack = 1'b1;
        end
    end

    // Run limit, armed per test by run_test
    initial begin
        wait (cyc > limit);
        $display("Timeout in %0s: %0d of %0d writes seen after %0d clocks",
                 test_name, wr_cnt, exp_n, cyc);
        report_counts();
        $display("test failed");
        $finish;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Returns {new cc, result}
    function automatic logic [15:0] alu_ref(alu_fn_e fn, logic [7:0] acc, logic [7:0] m,
                                            logic [7:0] cc);
        logic [7:0] r;
        logic [7:0] nc;
        int         s;
        int         sv;                 // Signed view of the same operation
        nc       = cc;
        nc[CC_V] = 1'b0;
        case (fn)
            FN_ADD, FN_ADC: begin
                s  = int'(acc) + int'(m) + ((fn == FN_ADC) ? int'(cc[CC_C]) : 0);
                sv = int'($signed(acc)) + int'($signed(m)) +
                     ((fn == FN_ADC) ? int'(cc[CC_C]) : 0);
                r = s[7:0];
                nc[CC_C] = s > 255;
                nc[CC_V] = sv > 127 || sv < -128;
            end
            FN_SUB, FN_CMP: begin
                sv = int'($signed(acc)) - int'($signed(m));
                r = acc - m;
                nc[CC_C] = acc < m;   // Borrow
                nc[CC_V] = sv > 127 || sv < -128;
            end
            FN_AND:  r = acc & m;
            FN_OR:   r = acc | m;
            FN_EOR:  r = acc ^ m;
            default: r = m;
        endcase
        nc[CC_N] = r[7];
        nc[CC_Z] = r == 8'd0;
        return {nc, r};
    endfunction

    task automatic put(input logic [7:0] v);
        img[pb] = v;
        pb++;
    endtask

    task automatic put_alu(input alu_fn_e fn, input logic rsel, input logic [1:0] mode);
        put({GRP_ALU, fn, rsel, mode});
    endtask

    task automatic put_st(input logic rsel, input logic [1:0] mode);
        put({GRP_ST, 3'd0, rsel, mode});
    endtask

    task automatic put_br(input logic [1:0] cond, input logic [7:0] ofs);
        put({GRP_BR, cond, 4'd0});
        put(ofs);
    endtask

    task automatic fill_image();
        logic [15:0] a;
        for (int i = 0; i < 65536; i++) begin
            a      = 16'(i);
            img[i] = a[15:8] ^ {a[6:0], a[7]} ^ 8'hA5;
        end
        pb = 16'h0000;
    endtask

    // Random immediate and extended ALU ops, each followed by an extended store
    task automatic build_alu_prog(input int n);
        logic [31:0] r2;
        fill_image();
        rng = lcg_step(rng);
        put_alu(FN_LD, 1'b0, MODE_IMM);
        put(rng[31:24]);
        put_alu(FN_LD, 1'b1, MODE_IMM);
        put(rng[23:16]);
        for (int i = 0; i < n; i++) begin
            rng = lcg_step(rng);
            r2  = lcg_step(rng);
            if (rng[29:28] == 2'b00) begin
                put_alu(alu_fn_e'(rng[26:24]), rng[27], MODE_EXT);
                put({4'h6, r2[31:28]});
                put(r2[23:16]);
            end else begin
                put_alu(alu_fn_e'(rng[26:24]), rng[27], MODE_IMM);
                put(r2[23:16]);
            end
            put_st(rng[31], MODE_EXT);
            put(8'h80);
            put(8'(i));
        end
        put_br(COND_ALWAYS, 8'hFE);
    endtask

    // Each block stores the marker of the path that the flags select
    task automatic build_branch_prog(input int n);
        logic [7:0] v1;
        logic [7:0] v2;
        fill_image();
        for (int i = 0; i < n; i++) begin
            rng = lcg_step(rng);
            v1  = rng[31:24];
            v2  = rng[27] ? v1 : rng[23:16];
            put_alu(FN_LD, 1'b0, MODE_IMM);
            put(v1);
            put_alu(rng[26] ? FN_CMP : FN_SUB, 1'b0, MODE_IMM);
            put(v2);
            put_br(2'(i % 3 + 1), 8'd4);   // EQ, NE, CS in turn
            put_alu(FN_LD, 1'b1, MODE_IMM);
            put(8'hA0 + 8'(i));
            put_br(COND_ALWAYS, 8'd2);
            put_alu(FN_LD, 1'b1, MODE_IMM);
            put(8'h50 + 8'(i));
            put_st(1'b1, MODE_EXT);
            put(8'h90);
            put(8'(i));
        end
        put_br(COND_ALWAYS, 8'hFE);
    endtask

    // Table at 4000h, read at even and written at odd addresses
    task automatic build_index_prog(input int n);
        fill_image();
        put(OP_LDX);
        put(8'h40);
        put(8'h00);
        for (int i = 0; i < n; i++) begin
            rng = lcg_step(rng);
            img[16'h4000 + 16'(2 * i)] = rng[31:24];
            put_alu(FN_LD, i[0], MODE_IDX);
            put_alu(FN_ADD, i[0], MODE_IMM);
            put(rng[23:16]);
            put_st(i[0], MODE_IDX);
        end
        put_br(COND_ALWAYS, 8'hFE);
    endtask

    // ISA model over a copy of the image, fills the expected write list
    task automatic ref_run(output int n_instr, output logic [15:0] end_pc);
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  cc;
        logic [7:0]  m;
        logic [15:0] x;
        logic [15:0] pc;
        logic [15:0] ea;
        logic [15:0] res;
        logic        take;
        logic        stop;
        op_u         o;
        for (int i = 0; i < 65536; i++) rm[i] = img[i];
        a = '0;
        b = '0;
        cc = '0;
        x = '0;
        pc = '0;
        exp_n = 0;
        n_instr = 0;
        stop = 1'b0;
        while (!stop && n_instr < 1000) begin
            o = op_u'(rm[pc]);
            n_instr++;
            ea = x;
            case (o.alu.grp)
                GRP_ALU, GRP_ST: begin
                    if (o.alu.mode == MODE_EXT) begin
                        ea = {rm[pc + 16'd1], rm[pc + 16'd2]};
                        pc = pc + 16'd3;
                    end else if (o.alu.mode == MODE_IDX) begin
                        x  = x + 16'd1;
                        pc = pc + 16'd1;
                    end else if (o.alu.mode == MODE_IMM && o.alu.grp == GRP_ALU) begin
                        ea = pc + 16'd1;
                        pc = pc + 16'd2;
                    end else begin
                        o  = op_u'(OP_NOP);   // Executes as NOP
                        pc = pc + 16'd1;
                    end
                    if (o.alu.grp == GRP_ALU) begin
                        m   = rm[ea];
                        res = alu_ref(o.alu.fn, o.alu.rsel ? b : a, m, cc);
                        cc  = res[15:8];
                        if (o.alu.fn != FN_CMP && o.alu.rsel) b = res[7:0];
                        if (o.alu.fn != FN_CMP && !o.alu.rsel) a = res[7:0];
                    end else if (o.alu.grp == GRP_ST) begin
                        rm[ea] = o.alu.rsel ? b : a;
                        exp_list[exp_n] = {ea, rm[ea]};
                        exp_n++;
                    end
                end
                GRP_BR: begin
                    m = rm[pc + 16'd1];
                    stop = o.br.cond == COND_ALWAYS && m == 8'hFE;
                    case (o.br.cond)
                        COND_EQ: take = cc[CC_Z];
                        COND_NE: take = !cc[CC_Z];
                        COND_CS: take = cc[CC_C];
                        default: take = 1'b1;
                    endcase
                    pc = pc + 16'd2 + (take ? {{8{m[7]}}, m} : 16'd0);
                end
                default: begin
                    if (rm[pc] == OP_LDX) begin
                        x  = {rm[pc + 16'd1], rm[pc + 16'd2]};
                        pc = pc + 16'd3;
                    end else begin
                        pc = pc + 16'd1;
                    end
                end
            endcase
        end
        end_pc = pc;   // Address of the closing self-branch
    endtask

    task automatic report_counts();
        $display("errors: value %0d, extra %0d, missing %0d, halt %0d",
                 err_val, err_extra, err_missing, err_halt);
    endtask

    task automatic run_test(input logic [127:0] name, input logic stall, input logic use_halt);
        int          n_instr;
        int          h_start;
        logic [15:0] end_pc;
        logic        at_end;
        test_name = name;
        @(posedge clk);
        #1;
        rst_n    = 1'b0;
        halt     = 1'b0;
        load_img = 1'b1;
        ref_run(n_instr, end_pc);
        repeat (8) begin
            @(posedge clk);
            #1;
            load_img = 1'b0;
        end
        rng      = lcg_step(rng);
        h_start  = 20 + int'(rng[29:24]);
        cyc      = 0;
        limit    = n_instr * 4 * 2 * STALL + (use_halt ? HALT_LEN : 0) + 64;
        rst_n    = 1'b1;
        stall_en = stall;
        at_end   = 1'b0;
        while (!at_end) begin
            @(posedge clk);
            #1;
            cyc++;
            if (use_halt) halt = cyc >= h_start && cyc < h_start + HALT_LEN;
            @(negedge clk);
            at_end = cen_out && is_op && addr == end_pc;   // Closing branch fetched
        end
        @(posedge clk);
        #1;
        halt     = 1'b0;
        stall_en = 1'b0;
        repeat (40) @(posedge clk);   // Catch writes past the closing branch
        #1;
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
    endtask

    initial begin
        seed_alu = rng;
        build_alu_prog(24);
        run_test("alu_flags", 1'b0, 1'b0);
        build_branch_prog(12);
        run_test("branches", 1'b0, 1'b0);
        build_index_prog(8);
        run_test("indexed", 1'b0, 1'b0);
        rng = seed_alu;
        build_alu_prog(24);
        run_test("backpressure", 1'b1, 1'b0);
        rng = seed_alu;
        build_alu_prog(24);
        run_test("halt", 1'b0, 1'b1);
        report_counts();
        if (err_val + err_extra + err_missing + err_halt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
kcpu_isa_pkg.sv
kcpu_bus_pkg.sv
kcpu_alu.sv
kcpu_regs.sv
kcpu_ctrl.sv
kcpu_memctrl.sv
kcpu.sv
kcpu_checker.sv
kcpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module kcpu_tb -o kcpu_sim \
    > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/kcpu_sim > sim.log 2>&1 || echo "Simulator exited with an error"
grep -qx "test passed" sim.log && echo "Simulation PASSED" || { echo "Simulation FAILED"; exit 1; }
